//--- adc_acq_pkg.sv
`default_nettype none

package adc_acq_pkg;

    // bit positions in the one-hot state vector
    typedef enum logic [4:0] {
        idle           = 5'd0,
        watch_for_trig = 5'd1,
        fill_init1     = 5'd2,
        fill_init2     = 5'd3,
        waveform_init1 = 5'd4,
        waveform_init2 = 5'd5,
        waveform_init3 = 5'd6,
        run1           = 5'd7,
        run2           = 5'd8,
        run3           = 5'd9,
        run4           = 5'd10,
        waveform_tst1  = 5'd11,
        waveform_tst2  = 5'd12,
        checksum1      = 5'd13,
        checksum2      = 5'd14,
        ddr3_wait      = 5'd15,
        done           = 5'd16
    } acq_state_e;

    localparam int NUM_STATES = 17;

    // one bit per state, exactly one set
    typedef logic [NUM_STATES-1:0] acq_state_vec_t;

    // {acq_enable1, acq_enable0} picks the burst count downstream
    localparam int FILL_TYPE_W = 2;

    // defaults for the top level parameters
    localparam int DEF_SYNC_STAGES     = 4;
    localparam int DEF_CBUF_RD_LATENCY = 2;

endpackage

`default_nettype wire

//--- adc_acq_phase_if.sv
`default_nettype none

// one-cycle strobes decoded from the sequencer next state
interface adc_acq_phase_if;

    logic fill_hdr_sel;
    logic fill_hdr_wr;
    logic wfm_start;
    logic wfm_hdr_sel;
    logic wfm_hdr_wr;
    logic burst_first;
    logic burst_word;
    logic burst_last;
    logic tail;
    logic cksum_sel;
    logic cksum_wr;

    modport seq (
        output fill_hdr_sel, fill_hdr_wr, wfm_start, wfm_hdr_sel, wfm_hdr_wr,
        output burst_first, burst_word, burst_last, tail, cksum_sel, cksum_wr
    );

    // frame side needs every phase
    modport frame (
        input fill_hdr_sel, fill_hdr_wr, wfm_start, wfm_hdr_sel, wfm_hdr_wr,
        input burst_first, burst_word, burst_last, tail, cksum_sel, cksum_wr
    );

    // buffer side only cares about waveform start, burst and tail
    modport cbuf (
        input wfm_start, wfm_hdr_wr, burst_word, burst_last, tail
    );

endinterface

`default_nettype wire

//--- adc_acq_input_sync.sv
`default_nettype none

module adc_acq_input_sync import adc_acq_pkg::*; #(
    parameter int SYNC_STAGES = 4
) (
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    input  logic                   acq_enable0,
    input  logic                   acq_enable1,
    input  logic                   acq_trig,
    input  logic                   ddr3_wr_done,
    output logic [FILL_TYPE_W-1:0] fill_type,
    output logic                   mode_enabled,
    output logic                   acq_trig_s,
    output logic                   ddr3_wr_done_s,
    output logic                   trig_pulse
);

    // one lane per async input, {trig, enable1, enable0}
    logic [SYNC_STAGES-1:0][2:0] sync_q;
    // done input comes from a slower domain, two flops are enough
    logic [1:0] done_q;
    // last synchronized trigger, for the edge detect
    logic trig_d;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            sync_q       <= '0;
            done_q       <= '0;
            trig_d       <= 1'b0;
            mode_enabled <= 1'b0;
            fill_type    <= '0;
            trig_pulse   <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], {acq_trig, acq_enable1, acq_enable0}};
            done_q <= {done_q[0], ddr3_wr_done};
            trig_d <= acq_trig_s;
            // armed whenever either enable is set
            mode_enabled <= sync_q[SYNC_STAGES-1][1] | sync_q[SYNC_STAGES-1][0];
            fill_type    <= sync_q[SYNC_STAGES-1][1:0];
            // rising edge only, and only while armed
            trig_pulse <= acq_trig_s & ~trig_d & mode_enabled;
        end
    end

    assign acq_trig_s     = sync_q[SYNC_STAGES-1][2];
    assign ddr3_wr_done_s = done_q[1];

endmodule

`default_nettype wire

//--- adc_acq_sequencer.sv
`default_nettype none

module adc_acq_sequencer import adc_acq_pkg::*; (
    input  logic            clk,
    input  logic            adc_acq_full_reset,
    input  logic            mode_enabled,
    input  logic            acq_trig_s,
    input  logic            trig_fifo_empty,
    input  logic            burst_cntr_zero,
    input  logic            ddr3_wr_done_s,
    adc_acq_phase_if.seq    phase,
    output logic            sm_idle,
    output logic            acq_enabled,
    output logic            acq_done
);

    acq_state_vec_t cs;
    acq_state_vec_t ns;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            cs       <= '0;
            cs[idle] <= 1'b1;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = '0;
        unique case (1'b1)
            // wait to be armed
            cs[idle]:           ns[mode_enabled ? watch_for_trig : idle] = 1'b1;
            // a trigger address in the FIFO starts a fill
            cs[watch_for_trig]: ns[trig_fifo_empty ? watch_for_trig : fill_init1] = 1'b1;
            cs[fill_init1]:     ns[fill_init2] = 1'b1;
            cs[fill_init2]:     ns[waveform_init1] = 1'b1;
            cs[waveform_init1]: ns[waveform_init2] = 1'b1;
            cs[waveform_init2]: ns[waveform_init3] = 1'b1;
            cs[waveform_init3]: ns[run1] = 1'b1;
            // four words per burst
            cs[run1]:           ns[run2] = 1'b1;
            cs[run2]:           ns[run3] = 1'b1;
            cs[run3]:           ns[run4] = 1'b1;
            cs[run4]:           ns[burst_cntr_zero ? waveform_tst1 : run1] = 1'b1;
            // two tail cycles let the buffer read latency drain
            cs[waveform_tst1]:  ns[waveform_tst2] = 1'b1;
            cs[waveform_tst2]:  ns[checksum1] = 1'b1;
            cs[checksum1]:      ns[checksum2] = 1'b1;
            cs[checksum2]:      ns[ddr3_wait] = 1'b1;
            // hold until DDR3 side has written everything out
            cs[ddr3_wait]:      ns[ddr3_wr_done_s ? done : ddr3_wait] = 1'b1;
            // no retrigger while the trigger is still high
            cs[done]:           ns[(mode_enabled && acq_trig_s) ? done : idle] = 1'b1;
            default:            ns[idle] = 1'b1;
        endcase
    end

    // phase strobes come from the next state, so registered outputs
    // line up with state entry
    assign phase.fill_hdr_sel = ns[fill_init1];
    assign phase.fill_hdr_wr  = ns[fill_init2];
    assign phase.wfm_start    = ns[waveform_init1];
    assign phase.wfm_hdr_sel  = ns[waveform_init2];
    assign phase.wfm_hdr_wr   = ns[waveform_init3];
    assign phase.burst_first  = ns[run1];
    assign phase.burst_word   = ns[run1] | ns[run2] | ns[run3] | ns[run4];
    assign phase.burst_last   = ns[run4];
    assign phase.tail         = ns[waveform_tst1] | ns[waveform_tst2];
    assign phase.cksum_sel    = ns[checksum1];
    assign phase.cksum_wr     = ns[checksum2];

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            sm_idle     <= 1'b1;
            acq_enabled <= 1'b0;
            acq_done    <= 1'b0;
        end else begin
            sm_idle <= ns[idle];
            // low while DDR3 may be read, i.e. idle or waiting for a trigger
            acq_enabled <= ~(ns[idle] | ns[watch_for_trig]);
            acq_done    <= ns[done];
        end
    end

    // state register must never lose or gain a hot bit
    a_state_onehot: assert property (
        @(posedge clk) disable iff (adc_acq_full_reset) $onehot(cs)
    );

endmodule

`default_nettype wire

//--- adc_acq_frame_ctrl.sv
`default_nettype none

module adc_acq_frame_ctrl (
    input  logic            clk,
    input  logic            adc_acq_full_reset,
    input  logic            dummy_dat_reset_mode,
    adc_acq_phase_if.frame  phase,
    output logic            adc_mux_fill_hdr_sel,
    output logic            adc_mux_wfm_hdr_sel,
    output logic            adc_mux_dat_sel,
    output logic            adc_mux_checksum_select,
    output logic            burst_cntr_init,
    output logic            burst_cntr_en,
    output logic            fill_cntr_en,
    output logic            address_cntr_en,
    output logic            dummy_dat_reset,
    output logic            hdr_wr_pulse
);

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            adc_mux_fill_hdr_sel    <= 1'b0;
            adc_mux_wfm_hdr_sel     <= 1'b0;
            adc_mux_dat_sel         <= 1'b0;
            adc_mux_checksum_select <= 1'b0;
            burst_cntr_init         <= 1'b0;
            burst_cntr_en           <= 1'b0;
            fill_cntr_en            <= 1'b0;
            address_cntr_en         <= 1'b0;
            dummy_dat_reset         <= 1'b0;
            hdr_wr_pulse            <= 1'b0;
        end else begin
            // mux selects, one per frame word type
            adc_mux_fill_hdr_sel    <= phase.fill_hdr_sel;
            adc_mux_wfm_hdr_sel     <= phase.wfm_hdr_sel;
            // data stays selected through the tail so late words get through
            adc_mux_dat_sel         <= phase.burst_word | phase.tail;
            adc_mux_checksum_select <= phase.cksum_sel;
            // burst count loads with the waveform header, decrements per burst
            burst_cntr_init <= phase.wfm_hdr_sel;
            burst_cntr_en   <= phase.burst_first;
            fill_cntr_en    <= phase.cksum_wr;
            // one address step per word written to the FIFO
            address_cntr_en <= phase.fill_hdr_wr | phase.wfm_hdr_wr |
                               phase.burst_last | phase.cksum_wr;
            // 0 keeps the dummy counter free running, 1 restarts it per waveform
            dummy_dat_reset <= phase.wfm_start & dummy_dat_reset_mode;
            // header and checksum writes go straight to the merge
            hdr_wr_pulse <= phase.fill_hdr_wr | phase.wfm_hdr_wr | phase.cksum_wr;
        end
    end

    // the output mux can only take one source
    a_mux_sel_onehot0: assert property (
        @(posedge clk) disable iff (adc_acq_full_reset)
        $onehot0({adc_mux_fill_hdr_sel, adc_mux_wfm_hdr_sel,
                  adc_mux_dat_sel, adc_mux_checksum_select})
    );

endmodule

`default_nettype wire

//--- adc_acq_cbuf_rd_ctrl.sv
`default_nettype none

module adc_acq_cbuf_rd_ctrl #(
    parameter int CBUF_RD_LATENCY = 2
) (
    input  logic            clk,
    input  logic            adc_acq_full_reset,
    adc_acq_phase_if.cbuf   phase,
    output logic            init_circ_buf_rd_addr,
    output logic            inc_circ_buf_rd_addr,
    output logic            trig_addr_rd_en,
    output logic            latch_circ_buf_dat,
    output logic            burst_wr_pulse
);

    // bit 0 is the registered burst_last, bit CBUF_RD_LATENCY the delayed write
    logic [CBUF_RD_LATENCY:0] wr_dly;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            init_circ_buf_rd_addr <= 1'b0;
            inc_circ_buf_rd_addr  <= 1'b0;
            trig_addr_rd_en       <= 1'b0;
            latch_circ_buf_dat    <= 1'b0;
            wr_dly                <= '0;
        end else begin
            // load start address and pop the FWFT trigger FIFO together
            init_circ_buf_rd_addr <= phase.wfm_start;
            trig_addr_rd_en       <= phase.wfm_start;
            // first step with the header write, data not valid yet
            inc_circ_buf_rd_addr <= phase.wfm_hdr_wr | phase.burst_word;
            // tail cycles pick up the words still in the read pipe
            latch_circ_buf_dat <= phase.burst_word | phase.tail;
            wr_dly <= {wr_dly[CBUF_RD_LATENCY-1:0], phase.burst_last};
        end
    end

    // burst lands in the FIFO once its last word has come out of the buffer
    assign burst_wr_pulse = wr_dly[CBUF_RD_LATENCY];

    // only two tail states exist to cover the read delay
    a_latency_range: assert property (
        @(posedge clk) CBUF_RD_LATENCY inside {[1:2]}
    );

endmodule

`default_nettype wire

//--- adc_acq_fifo_wr_merge.sv
`default_nettype none

module adc_acq_fifo_wr_merge (
    input  logic clk,
    input  logic adc_acq_full_reset,
    input  logic hdr_wr_pulse,
    input  logic burst_wr_pulse,
    output logic adc_acq_out_valid,
    output logic adc_mux_checksum_update
);

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            adc_acq_out_valid       <= 1'b0;
            adc_mux_checksum_update <= 1'b0;
        end else begin
            adc_acq_out_valid <= hdr_wr_pulse | burst_wr_pulse;
            // only data bursts feed the checksum
            adc_mux_checksum_update <= burst_wr_pulse;
        end
    end

    // a delayed burst write must clear before the checksum write
    a_no_wr_overlap: assert property (
        @(posedge clk) disable iff (adc_acq_full_reset)
        !(hdr_wr_pulse && burst_wr_pulse)
    );

endmodule

`default_nettype wire

//--- adc_acq_top.sv
`default_nettype none

module adc_acq_top import adc_acq_pkg::*; #(
    parameter int SYNC_STAGES     = DEF_SYNC_STAGES,
    parameter int CBUF_RD_LATENCY = DEF_CBUF_RD_LATENCY
) (
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    input  logic                   acq_enable0,
    input  logic                   acq_enable1,
    input  logic                   acq_trig,
    input  logic                   trig_fifo_empty,
    input  logic                   burst_cntr_zero,
    input  logic                   ddr3_wr_done,
    input  logic                   dummy_dat_reset_mode,
    output logic [FILL_TYPE_W-1:0] fill_type,
    output logic                   trig_pulse,
    output logic                   acq_enabled,
    output logic                   acq_done,
    output logic                   sm_idle,
    output logic                   address_cntr_en,
    output logic                   dummy_dat_reset,
    output logic                   adc_mux_fill_hdr_sel,
    output logic                   adc_mux_wfm_hdr_sel,
    output logic                   adc_mux_dat_sel,
    output logic                   adc_mux_checksum_select,
    output logic                   adc_mux_checksum_update,
    output logic                   burst_cntr_init,
    output logic                   burst_cntr_en,
    output logic                   fill_cntr_en,
    output logic                   adc_acq_out_valid,
    output logic                   init_circ_buf_rd_addr,
    output logic                   inc_circ_buf_rd_addr,
    output logic                   trig_addr_rd_en,
    output logic                   latch_circ_buf_dat
);

    // synchronized levels into the sequencer
    logic mode_enabled;
    logic acq_trig_s;
    logic ddr3_wr_done_s;
    // write strobes into the merge
    logic hdr_wr_pulse;
    logic burst_wr_pulse;

    adc_acq_phase_if phase ();

    adc_acq_input_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_input_sync (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .ddr3_wr_done       (ddr3_wr_done),
        .fill_type          (fill_type),
        .mode_enabled       (mode_enabled),
        .acq_trig_s         (acq_trig_s),
        .ddr3_wr_done_s     (ddr3_wr_done_s),
        .trig_pulse         (trig_pulse)
    );

    adc_acq_sequencer u_sequencer (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .mode_enabled       (mode_enabled),
        .acq_trig_s         (acq_trig_s),
        .trig_fifo_empty    (trig_fifo_empty),
        .burst_cntr_zero    (burst_cntr_zero),
        .ddr3_wr_done_s     (ddr3_wr_done_s),
        .phase              (phase.seq),
        .sm_idle            (sm_idle),
        .acq_enabled        (acq_enabled),
        .acq_done           (acq_done)
    );

    adc_acq_frame_ctrl u_frame_ctrl (
        .clk                     (clk),
        .adc_acq_full_reset      (adc_acq_full_reset),
        .dummy_dat_reset_mode    (dummy_dat_reset_mode),
        .phase                   (phase.frame),
        .adc_mux_fill_hdr_sel    (adc_mux_fill_hdr_sel),
        .adc_mux_wfm_hdr_sel     (adc_mux_wfm_hdr_sel),
        .adc_mux_dat_sel         (adc_mux_dat_sel),
        .adc_mux_checksum_select (adc_mux_checksum_select),
        .burst_cntr_init         (burst_cntr_init),
        .burst_cntr_en           (burst_cntr_en),
        .fill_cntr_en            (fill_cntr_en),
        .address_cntr_en         (address_cntr_en),
        .dummy_dat_reset         (dummy_dat_reset),
        .hdr_wr_pulse            (hdr_wr_pulse)
    );

    adc_acq_cbuf_rd_ctrl #(
        .CBUF_RD_LATENCY (CBUF_RD_LATENCY)
    ) u_cbuf_rd_ctrl (
        .clk                   (clk),
        .adc_acq_full_reset    (adc_acq_full_reset),
        .phase                 (phase.cbuf),
        .init_circ_buf_rd_addr (init_circ_buf_rd_addr),
        .inc_circ_buf_rd_addr  (inc_circ_buf_rd_addr),
        .trig_addr_rd_en       (trig_addr_rd_en),
        .latch_circ_buf_dat    (latch_circ_buf_dat),
        .burst_wr_pulse        (burst_wr_pulse)
    );

    adc_acq_fifo_wr_merge u_fifo_wr_merge (
        .clk                     (clk),
        .adc_acq_full_reset      (adc_acq_full_reset),
        .hdr_wr_pulse            (hdr_wr_pulse),
        .burst_wr_pulse          (burst_wr_pulse),
        .adc_acq_out_valid       (adc_acq_out_valid),
        .adc_mux_checksum_update (adc_mux_checksum_update)
    );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic adc_acq_full_reset
);

    // free running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held for a fixed number of rising edges
    initial begin
        adc_acq_full_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        adc_acq_full_reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tb_adc_acq.sv
`default_nettype none

module tb_adc_acq import adc_acq_pkg::*; ();

    localparam int NUM_ROWS = 6;

    logic clk;
    logic adc_acq_full_reset;
    logic acq_enable0          = 1'b0;
    logic acq_enable1          = 1'b0;
    logic acq_trig             = 1'b0;
    logic trig_fifo_empty      = 1'b1;
    logic burst_cntr_zero      = 1'b0;
    logic ddr3_wr_done         = 1'b0;
    logic dummy_dat_reset_mode = 1'b0;
    logic [FILL_TYPE_W-1:0] fill_type;
    logic trig_pulse, acq_enabled, acq_done, sm_idle, address_cntr_en, dummy_dat_reset;
    logic adc_mux_fill_hdr_sel, adc_mux_wfm_hdr_sel, adc_mux_dat_sel;
    logic adc_mux_checksum_select, adc_mux_checksum_update;
    logic burst_cntr_init, burst_cntr_en, fill_cntr_en, adc_acq_out_valid;
    logic init_circ_buf_rd_addr, inc_circ_buf_rd_addr, trig_addr_rd_en, latch_circ_buf_dat;

    // stimulus table with one array per column
    string row_name  [NUM_ROWS];
    bit    row_en1   [NUM_ROWS];
    bit    row_en0   [NUM_ROWS];
    int    row_n     [NUM_ROWS];
    bit    row_dmode [NUM_ROWS];
    int    row_dly   [NUM_ROWS];

    string cur_name;
    int    cur_n, cur_dly, bcnt, ddr3_cnt;
    int    seed = 55;
    int    err_count, errs_before, tests_run, tests_passed;
    int    cycle_cnt;
    int    cycle_limit = 1000000;
    // per-test strobe counters sampled on the falling edge
    int    ncyc, cnt_valid, cnt_addr, cnt_upd, cnt_inc, cnt_latch, cnt_ben, cnt_binit;
    int    cnt_iaddr, cnt_trd, cnt_fill, cnt_dummy, cnt_tpulse, cnt_not_idle, cnt_enabled;
    int    cnt_wsel, cnt_dsel;
    int    cnt_early_done;
    bit    ddr3_seen;
    // cycle stamps for write ordering
    int    first_valid, last_valid, fill_sel_cyc, cksum_sel_cyc, first_upd, last_upd;
    int    first_ben;

    tb_clk_gen #(.PERIOD(8), .RESET_CYCLES(5)) u_clk_gen (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset)
    );

    adc_acq_top dut (.*);

    // burst counter whose zero flag is set by the decrement that empties it
    always @(posedge clk) begin
        if (adc_acq_full_reset) begin
            bcnt            <= 0;
            burst_cntr_zero <= 1'b0;
        end else if (burst_cntr_init) begin
            bcnt            <= cur_n;
            burst_cntr_zero <= 1'b0;
        end else if (burst_cntr_en) begin
            bcnt            <= bcnt - 1;
            burst_cntr_zero <= (bcnt <= 1);
        end
    end

    // DDR3 side reports done some cycles after the fill starts and holds it until acq_done
    always @(posedge clk) begin
        if (adc_acq_full_reset || !acq_enabled) begin
            ddr3_cnt     <= 0;
            ddr3_wr_done <= 1'b0;
        end else if (acq_done) begin
            ddr3_wr_done <= 1'b0;
        end else if (!ddr3_wr_done) begin
            if (ddr3_cnt >= cur_dly)
                ddr3_wr_done <= 1'b1;
            else
                ddr3_cnt <= ddr3_cnt + 1;
        end
    end

    always @(negedge clk) begin
        ncyc++;
        if (trig_pulse) cnt_tpulse++;
        if (address_cntr_en) cnt_addr++;
        if (inc_circ_buf_rd_addr) cnt_inc++;
        if (latch_circ_buf_dat) cnt_latch++;
        if (burst_cntr_init) cnt_binit++;
        if (init_circ_buf_rd_addr) cnt_iaddr++;
        if (trig_addr_rd_en) cnt_trd++;
        if (fill_cntr_en) cnt_fill++;
        if (dummy_dat_reset) cnt_dummy++;
        if (adc_mux_wfm_hdr_sel) cnt_wsel++;
        if (adc_mux_dat_sel) cnt_dsel++;
        if (!sm_idle) cnt_not_idle++;
        if (acq_enabled) cnt_enabled++;
        if (adc_mux_fill_hdr_sel) fill_sel_cyc = ncyc;
        if (adc_mux_checksum_select) cksum_sel_cyc = ncyc;
        if (adc_acq_out_valid) begin
            cnt_valid++;
            if (first_valid < 0) first_valid = ncyc;
            last_valid = ncyc;
        end
        if (adc_mux_checksum_update) begin
            cnt_upd++;
            if (first_upd < 0) first_upd = ncyc;
            last_upd = ncyc;
        end
        if (burst_cntr_en) begin
            cnt_ben++;
            if (first_ben < 0) first_ben = ncyc;
        end
        // done may only follow a raised DDR3 done
        if (ddr3_wr_done) ddr3_seen = 1'b1;
        if (acq_done && !ddr3_seen) cnt_early_done++;
    end

    // run limit from the table length
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, the sequencer never reached done", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic set_row(input int i, input string name, input bit en1, input bit en0,
                           input int n, input bit dmode, input int dly);
        row_name[i]  = name;
        row_en1[i]   = en1;
        row_en0[i]   = en0;
        row_n[i]     = n;
        row_dmode[i] = dmode;
        row_dly[i]   = dly;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected !== actual) begin
            $display("Fail %s %s: expected %0d, actual %0d", cur_name, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic clear_counters();
        {cnt_valid, cnt_addr, cnt_upd, cnt_inc, cnt_latch, cnt_ben, cnt_binit} = '0;
        {cnt_iaddr, cnt_trd, cnt_fill, cnt_dummy, cnt_tpulse, cnt_not_idle} = '0;
        cnt_wsel       = 0;
        cnt_dsel       = 0;
        cnt_enabled    = 0;
        cnt_early_done = 0;
        ddr3_seen      = 1'b0;
        {first_valid, last_valid, fill_sel_cyc, cksum_sel_cyc} = {4{32'hffff_ffff}};
        {first_upd, last_upd, first_ben} = {3{32'hffff_ffff}};
    endtask

    task automatic report_test();
        tests_run++;
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s: ok", cur_name);
        end else begin
            $display("test %s: %0d failing checks", cur_name, err_count - errs_before);
        end
    endtask

    // expected counts per fill of n bursts are all zero when disarmed
    task automatic check_counts(input int i);
        int k;
        int n;
        k = (row_en1[i] || row_en0[i]) ? 1 : 0;
        n = row_n[i];
        check_value("trig_pulse count", k, cnt_tpulse);
        check_value("adc_acq_out_valid count", k * (n + 3), cnt_valid);
        check_value("address_cntr_en count", k * (n + 3), cnt_addr);
        check_value("adc_mux_checksum_update count", k * n, cnt_upd);
        check_value("inc_circ_buf_rd_addr count", k * (4 * n + 1), cnt_inc);
        check_value("latch_circ_buf_dat count", k * (4 * n + 2), cnt_latch);
        check_value("burst_cntr_en count", k * n, cnt_ben);
        check_value("burst_cntr_init count", k, cnt_binit);
        check_value("init_circ_buf_rd_addr count", k, cnt_iaddr);
        check_value("trig_addr_rd_en count", k, cnt_trd);
        check_value("fill_cntr_en count", k, cnt_fill);
        check_value("dummy_dat_reset count", k * row_dmode[i], cnt_dummy);
        // one waveform header per fill, data selected through bursts and tail
        check_value("adc_mux_wfm_hdr_sel count", k, cnt_wsel);
        check_value("adc_mux_dat_sel cycles", k * (4 * n + 2), cnt_dsel);
        check_value("acq_done before ddr3_wr_done", 0, cnt_early_done);
        if (k == 1) begin
            check_value("acq_enabled seen", 1, cnt_enabled > 0);
            // header write lands one cycle after its select and the merge adds one
            check_value("first valid cycle", fill_sel_cyc + 2, first_valid);
            check_value("last valid cycle", cksum_sel_cyc + 2, last_valid);
            check_value("updates after first valid", 1, first_upd > first_valid);
            check_value("updates before last valid", 1, last_upd < last_valid);
            // run1 to run4, read latency, then the merge stage
            check_value("first update cycle", first_ben + 4 + DEF_CBUF_RD_LATENCY, first_upd);
        end else begin
            check_value("sm_idle low cycles", 0, cnt_not_idle);
            check_value("acq_enabled cycles", 0, cnt_enabled);
        end
    endtask

    task automatic run_row(input int i);
        int gap;
        cur_name    = row_name[i];
        cur_n       = row_n[i];
        cur_dly     = row_dly[i];
        errs_before = err_count;
        @(posedge clk);
        acq_enable1          <= row_en1[i];
        acq_enable0          <= row_en0[i];
        dummy_dat_reset_mode <= row_dmode[i];
        acq_trig             <= 1'b0;
        // sync chain plus the mode register
        repeat (DEF_SYNC_STAGES + 4) @(posedge clk);
        clear_counters();
        @(negedge clk);
        check_value("fill_type", {row_en1[i], row_en0[i]}, fill_type);
        @(posedge clk);
        acq_trig <= 1'b1;
        if (row_en1[i] || row_en0[i]) begin
            gap = 1 + ({$random(seed)} % 8);
            repeat (gap) @(posedge clk);
            trig_fifo_empty <= 1'b0;
            // trigger FIFO empties once its address is popped
            do begin
                @(negedge clk);
            end while (!trig_addr_rd_en);
            @(posedge clk);
            trig_fifo_empty <= 1'b1;
            do begin
                @(negedge clk);
            end while (!acq_done);
            @(posedge clk);
            acq_trig <= 1'b0;
            do begin
                @(negedge clk);
            end while (!sm_idle);
            repeat (4) @(negedge clk);
        end else begin
            // while disarmed a queued trigger must not start a fill
            trig_fifo_empty <= 1'b0;
            repeat (16) @(posedge clk);
            acq_trig        <= 1'b0;
            trig_fifo_empty <= 1'b1;
            repeat (DEF_SYNC_STAGES + 8) @(posedge clk);
        end
        check_counts(i);
        report_test();
    endtask

    initial begin
        // name, enable1, enable0, bursts, dummy mode, DDR3 delay
        set_row(0, "disarmed",      1'b0, 1'b0, 0, 1'b1, 0);
        set_row(1, "type1_n1",      1'b0, 1'b1, 1, 1'b1, 3);
        set_row(2, "type2_n3",      1'b1, 1'b0, 3, 1'b0, 20);
        set_row(3, "type3_n5_slow", 1'b1, 1'b1, 5, 1'b1, 60);
        set_row(4, "type1_n2_fast", 1'b0, 1'b1, 2, 1'b0, 0);
        set_row(5, "type3_n8",      1'b1, 1'b1, 8, 1'b0, 10);
        cycle_limit = 0;
        for (int i = 0; i < NUM_ROWS; i++)
            cycle_limit += 4 * row_n[i] + 40 + row_dly[i];
        cycle_limit = cycle_limit * 2;
        do begin
            @(negedge clk);
        end while (adc_acq_full_reset);
        cur_name    = "after_reset";
        errs_before = err_count;
        check_value("sm_idle", 1, sm_idle);
        check_value("acq_enabled", 0, acq_enabled);
        check_value("trig_pulse", 0, trig_pulse);
        report_test();
        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i);
        $display("%0d tests, %0d passed, %0d failed, %0d failing checks",
                 tests_run, tests_passed, tests_run - tests_passed, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
adc_acq_pkg.sv
adc_acq_phase_if.sv
adc_acq_input_sync.sv
adc_acq_sequencer.sv
adc_acq_frame_ctrl.sv
adc_acq_cbuf_rd_ctrl.sv
adc_acq_fifo_wr_merge.sv
adc_acq_top.sv
tb_clk_gen.sv
tb_adc_acq.sv

//--- Bender.yml
package:
  name: adc_acq

sources:
  - files:
      - adc_acq_pkg.sv
      - adc_acq_phase_if.sv
      - adc_acq_input_sync.sv
      - adc_acq_sequencer.sv
      - adc_acq_frame_ctrl.sv
      - adc_acq_cbuf_rd_ctrl.sv
      - adc_acq_fifo_wr_merge.sv
      - adc_acq_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_adc_acq.sv
